// ==== soc_bus_pkg.sv ====
// Addresses are byte addresses and the I/O window is fixed, so only BRAM size is set by parameter
package soc_bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  wstrb_t;

  // Request from the bus master, held stable while valid is high
  typedef struct packed {
    logic   valid;
    logic   is_instr;
    addr_t  addr;
    data_t  wdata;
    wstrb_t wstrb;
  } bus_req_t;

  // Response from a target, ready is a single cycle pulse
  typedef struct packed {
    logic  ready;
    logic  fault;
    data_t rdata;
  } bus_rsp_t;

  typedef enum logic [1:0] {
    IDLE,
    START,
    DATA,
    STOP
  } uart_state_e;

  // The I/O window includes its upper bound
  localparam addr_t IO_BASE  = 32'h1000_0000;
  localparam addr_t IO_LIMIT = 32'h1200_0000;

  localparam addr_t UART_TX_ADDR  = 32'h1000_0000;
  localparam addr_t UART_LSR_ADDR = 32'h1000_0005;

  localparam addr_t DIV_ADDR      = 32'h1000_0010;
  localparam addr_t CPU_FREQ_ADDR = 32'h1000_0014;
  localparam addr_t MEM_SIZE_ADDR = 32'h1000_0018;
  localparam addr_t REBOOT_ADDR   = 32'h1100_0000;

  localparam logic [15:0] REBOOT_MAGIC = 16'h7777;

  // LSR byte sits in bits 15:8 of the read word, bits 5 and 6 flag an idle transmitter
  localparam data_t LSR_TX_IDLE_BITS = 32'h0000_6000;

endpackage

// ==== boot_reset.sv ====
// Holds the core in reset for RESET_HOLD_CYCLES after resetn or a reboot pulse; needs RESET_HOLD_CYCLES > 0
module boot_reset #(
  parameter int RESET_HOLD_CYCLES = 20
) (
  input  logic clk,
  input  logic resetn,
  input  logic reboot_req_i,
  output logic core_resetn_o
);

  localparam int CNT_W = $clog2(RESET_HOLD_CYCLES + 1);
  localparam logic [CNT_W-1:0] HOLD = CNT_W'(RESET_HOLD_CYCLES);

  logic [CNT_W-1:0] cnt_q;
  logic             released;

  assign released = (cnt_q == HOLD);

  // Counter saturates at HOLD and restarts from zero on either reset source
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cnt_q <= '0;
    end else if (reboot_req_i) begin
      cnt_q <= '0;
    end else if (!released) begin
      cnt_q <= cnt_q + 1'b1;
    end
  end

  // The core leaves reset in the cycle the count reaches HOLD
  assign core_resetn_o = released;

endmodule

// ==== bram.sv ====
// Word-wide RAM of BRAM_WORDS words (power of two); contents are undefined after power-up
module bram #(
  parameter int BRAM_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  sel_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o
);
  import soc_bus_pkg::*;

  localparam int IDX_W = $clog2(BRAM_WORDS);

  data_t            mem_q [BRAM_WORDS];
  data_t            rdata_q;
  logic             ready_q;
  logic [IDX_W-1:0] word_idx;

  assign word_idx = req_i.addr[IDX_W+1:2];

  // Read happens before the masked write, so a write returns the old word
  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_q <= mem_q[word_idx];
      for (int b = 0; b < 4; b++) begin
        if (req_i.wstrb[b]) begin
          mem_q[word_idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel_i;
    end
  end

  assign rsp_o = '{ready: ready_q, fault: 1'b0, rdata: rdata_q};

  // The router must not reselect while our response is still on the bus
  a_ready_single: assert property (@(posedge clk) disable iff (!resetn)
    ready_q |=> !ready_q)
    else $error("bram ready high two cycles in a row");

endmodule

// ==== sysreg_block.sv ====
// System registers answer every I/O access routed here; only DIV is writable and unknown addresses read 0
module sysreg_block #(
  parameter logic [31:0] SYSTEM_CLK_HZ  = 32'd25_000_000,
  parameter int unsigned MEM_SIZE_BYTES = 8 * 1024 * 1024
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  sel_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  output logic [15:0]           div_value_o,
  output logic                  reboot_req_o
);
  import soc_bus_pkg::*;

  data_t div_q;
  data_t rdata_q;
  data_t rdata_next;
  logic  ready_q;
  logic  reboot_q;
  logic  is_write;
  logic  reboot_hit;

  assign is_write   = |req_i.wstrb;
  assign reboot_hit = sel_i && is_write && (req_i.addr == REBOOT_ADDR) &&
                      (req_i.wdata[15:0] == REBOOT_MAGIC);

  always_comb begin
    case (req_i.addr)
      DIV_ADDR:      rdata_next = div_q;
      CPU_FREQ_ADDR: rdata_next = data_t'(SYSTEM_CLK_HZ);
      MEM_SIZE_ADDR: rdata_next = data_t'(MEM_SIZE_BYTES);
      default:       rdata_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      div_q    <= '0;
      ready_q  <= 1'b0;
      reboot_q <= 1'b0;
    end else begin
      ready_q  <= sel_i;
      reboot_q <= reboot_hit;
      if (sel_i && is_write && (req_i.addr == DIV_ADDR)) begin
        div_q <= req_i.wdata;
      end
    end
  end

  // Read data is captured on every access and only looked at while ready
  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_q <= rdata_next;
    end
  end

  assign rsp_o        = '{ready: ready_q, fault: 1'b0, rdata: rdata_q};
  assign div_value_o  = div_q[15:0];
  assign reboot_req_o = reboot_q;

endmodule

// ==== uart_tx.sv ====
// 8N1 transmitter with no FIFO; a TX write while a frame is in progress is acknowledged and dropped
module uart_tx (
  input  logic                  clk,
  input  logic                  resetn,
  input  logic                  sel_i,
  input  soc_bus_pkg::bus_req_t req_i,
  output soc_bus_pkg::bus_rsp_t rsp_o,
  input  logic [15:0]           div_value_i,
  output logic                  tx_o
);
  import soc_bus_pkg::*;

  uart_state_e state_q;
  logic [15:0] timer_q;
  logic [2:0]  bit_cnt_q;
  logic [7:0]  shift_q;
  logic        tx_q;
  logic        ready_q;
  data_t       rdata_q;
  logic        is_write;
  logic        tx_accept;
  logic        bit_done;

  assign is_write  = |req_i.wstrb;
  assign tx_accept = sel_i && is_write && (req_i.addr == UART_TX_ADDR) && (state_q == IDLE);
  assign bit_done  = (timer_q == '0);

  // Each bit lasts div_value_i + 1 clocks, the timer reloads at every bit edge
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state_q   <= IDLE;
      timer_q   <= '0;
      bit_cnt_q <= '0;
      tx_q      <= 1'b1;
    end else begin
      case (state_q)
        IDLE: begin
          if (tx_accept) begin
            state_q <= START;
            timer_q <= div_value_i;
            tx_q    <= 1'b0;
          end
        end
        START, DATA, STOP: begin
          if (!bit_done) begin
            timer_q <= timer_q - 1'b1;
          end else begin
            timer_q <= div_value_i;
            if (state_q == START) begin
              state_q   <= DATA;
              bit_cnt_q <= '0;
              tx_q      <= shift_q[0];
            end else if (state_q == DATA && bit_cnt_q != 3'd7) begin
              bit_cnt_q <= bit_cnt_q + 1'b1;
              tx_q      <= shift_q[1];
            end else if (state_q == DATA) begin
              state_q <= STOP;
              tx_q    <= 1'b1;
            end else begin
              state_q <= IDLE;
            end
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Shifter loads on accept and moves LSB first as each data bit completes
  always_ff @(posedge clk) begin
    if (tx_accept) begin
      shift_q <= req_i.wdata[7:0];
    end else if (state_q == DATA && bit_done) begin
      shift_q <= shift_q >> 1;
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      ready_q <= 1'b0;
    end else begin
      ready_q <= sel_i;
    end
  end

  always_ff @(posedge clk) begin
    if (sel_i) begin
      rdata_q <= (!is_write && req_i.addr == UART_LSR_ADDR && state_q == IDLE) ?
                 LSR_TX_IDLE_BITS : '0;
    end
  end

  assign rsp_o = '{ready: ready_q, fault: 1'b0, rdata: rdata_q};
  assign tx_o  = tx_q;

  a_idle_line_high: assert property (@(posedge clk) disable iff (!resetn)
    (state_q == IDLE) |-> tx_o)
    else $error("uart line low while idle");

endmodule

// ==== mem_router.sv ====
// Decodes one request at a time; the master must hold valid until ready and targets answer in one cycle
module mem_router #(
  parameter int BRAM_WORDS = 256
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output logic                  bram_sel_o,
  output logic                  uart_sel_o,
  output logic                  sys_sel_o,
  input  soc_bus_pkg::bus_rsp_t bram_rsp_i,
  input  soc_bus_pkg::bus_rsp_t uart_rsp_i,
  input  soc_bus_pkg::bus_rsp_t sys_rsp_i
);
  import soc_bus_pkg::*;

  localparam addr_t BRAM_LIMIT = addr_t'(BRAM_WORDS * 4);
  localparam addr_t UART_LAST  = UART_TX_ADDR + 32'd7;

  logic is_bram;
  logic is_io;
  logic is_uart;
  logic data_ok;
  logic access_fault;
  logic rsp_pending;
  logic req_open;
  logic fault_q;

  assign is_bram = (bus_req_i.addr < BRAM_LIMIT);
  assign is_io   = (bus_req_i.addr >= IO_BASE) && (bus_req_i.addr <= IO_LIMIT);
  assign is_uart = (bus_req_i.addr >= UART_TX_ADDR) && (bus_req_i.addr <= UART_LAST);

  // Instruction fetches may only come from BRAM
  assign data_ok      = !bus_req_i.is_instr;
  assign access_fault = bus_req_i.is_instr ? !is_bram : !(is_bram || is_io);

  // A response in flight blocks the held request from being issued twice
  assign rsp_pending = bram_rsp_i.ready | uart_rsp_i.ready | sys_rsp_i.ready | fault_q;
  assign req_open    = bus_req_i.valid && !rsp_pending;

  assign bram_sel_o = req_open && is_bram;
  assign uart_sel_o = req_open && data_ok && is_uart;
  assign sys_sel_o  = req_open && data_ok && is_io && !is_uart;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      fault_q <= 1'b0;
    end else begin
      fault_q <= req_open && access_fault;
    end
  end

  always_comb begin
    bus_rsp_o.ready = rsp_pending;
    bus_rsp_o.fault = fault_q | bram_rsp_i.fault | uart_rsp_i.fault | sys_rsp_i.fault;
    if (bram_rsp_i.ready) begin
      bus_rsp_o.rdata = bram_rsp_i.rdata;
    end else if (uart_rsp_i.ready) begin
      bus_rsp_o.rdata = uart_rsp_i.rdata;
    end else if (sys_rsp_i.ready) begin
      bus_rsp_o.rdata = sys_rsp_i.rdata;
    end else begin
      // faults and idle cycles carry zero data
      bus_rsp_o.rdata = '0;
    end
  end

  a_ready_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({bram_rsp_i.ready, uart_rsp_i.ready, sys_rsp_i.ready, fault_q}))
    else $error("more than one target answered");

  a_sel_onehot: assert property (@(posedge clk) disable iff (!resetn)
    $onehot0({bram_sel_o, uart_sel_o, sys_sel_o}))
    else $error("more than one target selected");

endmodule

// ==== soc_top.sv ====
// Bus port replaces the CPU; one request in flight and every region answers one cycle after valid
module soc_top #(
  parameter logic [31:0] SYSTEM_CLK_HZ     = 32'd25_000_000,
  parameter int unsigned MEM_SIZE_BYTES    = 8 * 1024 * 1024,
  parameter int          BRAM_WORDS        = 256,
  parameter int          RESET_HOLD_CYCLES = 20
) (
  input  logic                  clk,
  input  logic                  resetn,
  input  soc_bus_pkg::bus_req_t bus_req_i,
  output soc_bus_pkg::bus_rsp_t bus_rsp_o,
  output logic                  uart_tx_o,
  output logic                  core_resetn_o
);
  import soc_bus_pkg::*;

  logic        bram_sel;
  logic        uart_sel;
  logic        sys_sel;
  bus_rsp_t    bram_rsp;
  bus_rsp_t    uart_rsp;
  bus_rsp_t    sys_rsp;
  logic [15:0] div_value;
  logic        reboot_req;

  mem_router #(
    .BRAM_WORDS(BRAM_WORDS)
  ) router_i (
    .clk       (clk),
    .resetn    (resetn),
    .bus_req_i (bus_req_i),
    .bus_rsp_o (bus_rsp_o),
    .bram_sel_o(bram_sel),
    .uart_sel_o(uart_sel),
    .sys_sel_o (sys_sel),
    .bram_rsp_i(bram_rsp),
    .uart_rsp_i(uart_rsp),
    .sys_rsp_i (sys_rsp)
  );

  bram #(
    .BRAM_WORDS(BRAM_WORDS)
  ) bram_i (
    .clk   (clk),
    .resetn(resetn),
    .sel_i (bram_sel),
    .req_i (bus_req_i),
    .rsp_o (bram_rsp)
  );

  sysreg_block #(
    .SYSTEM_CLK_HZ (SYSTEM_CLK_HZ),
    .MEM_SIZE_BYTES(MEM_SIZE_BYTES)
  ) sysreg_i (
    .clk         (clk),
    .resetn      (resetn),
    .sel_i       (sys_sel),
    .req_i       (bus_req_i),
    .rsp_o       (sys_rsp),
    .div_value_o (div_value),
    .reboot_req_o(reboot_req)
  );

  uart_tx uart_i (
    .clk        (clk),
    .resetn     (resetn),
    .sel_i      (uart_sel),
    .req_i      (bus_req_i),
    .rsp_o      (uart_rsp),
    .div_value_i(div_value),
    .tx_o       (uart_tx_o)
  );

  // Bus registers stay on resetn, only the core reset follows a reboot
  boot_reset #(
    .RESET_HOLD_CYCLES(RESET_HOLD_CYCLES)
  ) boot_reset_i (
    .clk          (clk),
    .resetn       (resetn),
    .reboot_req_i (reboot_req),
    .core_resetn_o(core_resetn_o)
  );

endmodule

// ==== tb_soc_top.sv ====
// Expects the DUT parameters set below, one request in flight and DIV set to UART_DIV before the UART frames
module tb_soc_top;
  import soc_bus_pkg::*;

  localparam logic [31:0] CLK_HZ       = 32'd50_000_000;
  localparam int unsigned MEM_BYTES    = 4 * 1024 * 1024;
  localparam int          RAM_WORDS    = 128;
  localparam int          HOLD         = 12;
  localparam int          UART_DIV     = 3;
  localparam int          BIT_CLKS     = UART_DIV + 1;
  localparam int          UART_FRAMES  = 2;
  localparam int          RAM_TESTS    = 8;
  localparam int          RESET_CYCLES = 16;
  localparam int          MARGIN       = 300;
  // LSR is byte 1 of the read word, bits 5 and 6 flag an idle transmitter
  localparam data_t       LSR_IDLE     = 32'h0000_0060 << 8;

  typedef struct packed {
    logic   is_instr;
    addr_t  addr;
    data_t  wdata;
    wstrb_t wstrb;
    data_t  exp_rdata;
    logic   exp_fault;
  } vec_t;

  logic        clk;
  logic        resetn;
  bus_req_t    req;
  bus_rsp_t    rsp;
  logic        uart_tx;
  logic        core_resetn;
  vec_t        vec_table[$];
  data_t       model[RAM_WORDS];
  logic [31:0] rng_state;
  logic [7:0]  rx_bytes[$];
  int          cycle_cnt;
  int          cycle_limit;

  soc_top #(
    .SYSTEM_CLK_HZ    (CLK_HZ),
    .MEM_SIZE_BYTES   (MEM_BYTES),
    .BRAM_WORDS       (RAM_WORDS),
    .RESET_HOLD_CYCLES(HOLD)
  ) soc_top_i (
    .clk          (clk),
    .resetn       (resetn),
    .bus_req_i    (req),
    .bus_rsp_o    (rsp),
    .uart_tx_o    (uart_tx),
    .core_resetn_o(core_resetn)
  );

  always #5 clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Regression failed");
    $fatal(1);
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      abort_run($sformatf("Timeout after %0d cycles", cycle_cnt));
    end
  end

  function automatic logic [31:0] next_random(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input wstrb_t strb);
    data_t res;
    res = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic void add_row(input logic instr, input addr_t addr, input data_t wdata,
                                  input wstrb_t wstrb, input data_t exp_rdata,
                                  input logic exp_fault);
    vec_t row;
    row.is_instr  = instr;
    row.addr      = addr;
    row.wdata     = wdata;
    row.wstrb     = wstrb;
    row.exp_rdata = exp_rdata;
    row.exp_fault = exp_fault;
    vec_table.push_back(row);
  endfunction

  task automatic build_table();
    int     idx[RAM_TESTS];
    wstrb_t strb;
    for (int i = 0; i < RAM_TESTS; i++) begin
      idx[i] = (i * 37 + 3) % RAM_WORDS;
      rng_state = next_random(rng_state);
      model[idx[i]] = rng_state;
      add_row(1'b0, addr_t'(idx[i] * 4), rng_state, 4'hF, '0, 1'b0);
    end
    // Partial writes merge into the words written above
    for (int i = 0; i < RAM_TESTS; i++) begin
      rng_state = next_random(rng_state);
      strb = (rng_state[3:0] == 4'h0) ? 4'h4 : rng_state[3:0];
      model[idx[i]] = merge_bytes(model[idx[i]], rng_state, strb);
      add_row(1'b0, addr_t'(idx[i] * 4), rng_state, strb, '0, 1'b0);
    end
    for (int i = 0; i < RAM_TESTS; i++) begin
      add_row(1'b0, addr_t'(idx[i] * 4), '0, '0, model[idx[i]], 1'b0);
    end
    add_row(1'b1, addr_t'(idx[0] * 4), '0, '0, model[idx[0]], 1'b0);
    add_row(1'b0, CPU_FREQ_ADDR, '0, '0, CLK_HZ, 1'b0);
    add_row(1'b0, MEM_SIZE_ADDR, '0, '0, data_t'(MEM_BYTES), 1'b0);
    add_row(1'b0, CPU_FREQ_ADDR, 32'hdead_beef, 4'hF, '0, 1'b0);
    add_row(1'b0, CPU_FREQ_ADDR, '0, '0, CLK_HZ, 1'b0);
    add_row(1'b0, DIV_ADDR, 32'h0000_1234, 4'hF, '0, 1'b0);
    add_row(1'b0, DIV_ADDR, '0, '0, 32'h0000_1234, 1'b0);
    add_row(1'b0, DIV_ADDR, data_t'(UART_DIV), 4'hF, '0, 1'b0);
    add_row(1'b0, DIV_ADDR, '0, '0, data_t'(UART_DIV), 1'b0);
    add_row(1'b0, 32'h1000_0100, '0, '0, '0, 1'b0);
    add_row(1'b0, 32'h1200_0000, '0, '0, '0, 1'b0);
    add_row(1'b0, 32'h2000_0000, '0, '0, '0, 1'b1);
    add_row(1'b1, DIV_ADDR, '0, '0, '0, 1'b1);
    add_row(1'b0, addr_t'(RAM_WORDS * 4), 32'h5555_aaaa, 4'hF, '0, 1'b1);
    add_row(1'b0, 32'h1200_0004, '0, '0, '0, 1'b1);
  endtask

  // One access: valid in cycle k, response sampled in cycle k+1, valid dropped after
  task automatic bus_access(input logic instr, input addr_t addr, input data_t wdata,
                            input wstrb_t wstrb, output data_t rdata, output logic fault);
    bus_req_t r;
    r.valid    = 1'b1;
    r.is_instr = instr;
    r.addr     = addr;
    r.wdata    = wdata;
    r.wstrb    = wstrb;
    @(posedge clk);
    req <= r;
    @(negedge clk);
    assert (!rsp.ready) else abort_run($sformatf("ready came with valid at addr %08h", addr));
    @(negedge clk);
    assert (rsp.ready) else abort_run($sformatf("no ready one cycle after valid at addr %08h", addr));
    rdata = rsp.rdata;
    fault = rsp.fault;
    @(posedge clk);
    req <= '0;
  endtask

  // Read data is defined for reads and for faults, not for accepted writes
  task automatic check_access(input logic instr, input addr_t addr, input data_t wdata,
                              input wstrb_t wstrb, input data_t exp_rdata, input logic exp_fault);
    data_t rd;
    logic  flt;
    bus_access(instr, addr, wdata, wstrb, rd, flt);
    assert (flt == exp_fault) else abort_run($sformatf(
      "[ERROR] bus_rsp_o.fault at addr %08h: got %0h, expected %0h", addr, flt, exp_fault));
    if (wstrb == '0 || exp_fault) begin
      assert (rd == exp_rdata) else abort_run($sformatf(
        "[ERROR] bus_rsp_o.rdata at addr %08h: got %08h, expected %08h", addr, rd, exp_rdata));
    end
  endtask

  task automatic check_core_release();
    for (int i = 0; i <= HOLD; i++) begin
      @(negedge clk);
      assert (core_resetn == (i == HOLD)) else abort_run($sformatf(
        "[ERROR] core_resetn_o %0d cycles after release start: got %0h, expected %0h",
        i, core_resetn, i == HOLD));
    end
  endtask

  task automatic wait_uart_idle();
    data_t rd;
    logic  flt;
    int    polls;
    polls = 0;
    rd = '0;
    while (rd != LSR_IDLE) begin
      bus_access(1'b0, UART_LSR_ADDR, '0, '0, rd, flt);
      assert (!flt) else abort_run("LSR read returned a fault");
      assert (rd == LSR_IDLE || rd == '0) else abort_run($sformatf(
        "[ERROR] bus_rsp_o.rdata for LSR: got %08h, expected %08h or 0", rd, LSR_IDLE));
      polls++;
      assert (polls < 10 * BIT_CLKS) else abort_run($sformatf(
        "UART transmitter never went idle, state %s", soc_top_i.uart_i.state_q.name()));
    end
  endtask

  task automatic send_uart_byte(input logic [7:0] tx_byte, input logic [7:0] dropped);
    logic [7:0] got;
    check_access(1'b0, UART_LSR_ADDR, '0, '0, LSR_IDLE, 1'b0);
    check_access(1'b0, UART_TX_ADDR, {24'h0, tx_byte}, 4'h1, '0, 1'b0);
    check_access(1'b0, UART_LSR_ADDR, '0, '0, '0, 1'b0);
    // A byte written while busy is acknowledged and lost
    check_access(1'b0, UART_TX_ADDR, {24'h0, dropped}, 4'h1, '0, 1'b0);
    wait_uart_idle();
    assert (uart_tx == 1'b1) else abort_run("UART line low with the transmitter idle");
    assert (rx_bytes.size() == 1) else abort_run($sformatf(
      "UART monitor decoded %0d bytes for one frame", rx_bytes.size()));
    got = rx_bytes.pop_front();
    assert (got == tx_byte) else abort_run($sformatf(
      "[ERROR] uart_tx_o byte: got %02h, expected %02h", got, tx_byte));
  endtask

  // Sampled on the falling clock edge near mid-bit
  always begin : uart_monitor
    logic [7:0] byte_v;
    @(negedge uart_tx);
    repeat (BIT_CLKS / 2) @(negedge clk);
    assert (uart_tx == 1'b0) else abort_run("UART start bit too short");
    for (int i = 0; i < 8; i++) begin
      repeat (BIT_CLKS) @(negedge clk);
      byte_v[i] = uart_tx;
    end
    repeat (BIT_CLKS) @(negedge clk);
    assert (uart_tx == 1'b1) else abort_run("UART stop bit missing");
    rx_bytes.push_back(byte_v);
  end

  initial begin
    clk = 1'b0;
    resetn = 1'b0;
    req = '0;
    rng_state = 32'h2d1ace1e;
    cycle_cnt = 0;
    build_table();
    cycle_limit = vec_table.size() * 4 + UART_FRAMES * 10 * BIT_CLKS + 2 * HOLD +
                  RESET_CYCLES + MARGIN;
    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    assert (!core_resetn) else abort_run("core_resetn_o high during reset");
    @(posedge clk);
    resetn <= 1'b1;
    check_core_release();

    foreach (vec_table[i]) begin
      check_access(vec_table[i].is_instr, vec_table[i].addr, vec_table[i].wdata,
                   vec_table[i].wstrb, vec_table[i].exp_rdata, vec_table[i].exp_fault);
    end

    rng_state = next_random(rng_state);
    send_uart_byte(8'ha5, 8'h3c);
    send_uart_byte(rng_state[7:0], ~rng_state[7:0]);

    // Only the magic value restarts the core
    check_access(1'b0, REBOOT_ADDR, 32'h0000_1234, 4'hF, '0, 1'b0);
    repeat (2) @(negedge clk);
    assert (core_resetn) else abort_run("core_resetn_o dropped on a write without the magic");
    check_access(1'b0, REBOOT_ADDR, data_t'(REBOOT_MAGIC), 4'hF, '0, 1'b0);
    check_core_release();
    check_access(1'b0, DIV_ADDR, '0, '0, data_t'(UART_DIV), 1'b0);

    assert (rx_bytes.size() == 0) else abort_run("UART monitor decoded an unexpected byte");
    $display("Regression passed");
    $finish;
  end

endmodule

// ==== soc_bus.f ====
soc_bus_pkg.sv
boot_reset.sv
bram.sv
sysreg_block.sv
uart_tx.sv
mem_router.sv
soc_top.sv
tb_soc_top.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_soc_top -f soc_bus.f -o tb_soc_top
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_soc_top 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Regression passed"; then
  exit 0
fi
exit 1
